/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mips_core
FILELIST  := mips_core_lite.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides the result, since a failing run may stop early
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/mips_pkg.sv */
// Shared definitions for the MIPS core, imported by every stage that decodes or carries ops
`default_nettype none

package mips_pkg;

	localparam int REG_ADDR_W = 5;  // 32 architectural registers
	localparam int XLEN       = 32;

	typedef enum logic [3:0] {
		ALU_ADDU,
		ALU_SUBU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI,
		ALU_PASS1,  // Link address for JAL and JALR
		ALU_NONE
	} alu_op_e;

	// Condition is evaluated on the ALU result in the result stage
	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQZ,
		BR_NEZ,
		BR_UNCOND,  // Target computed in decode
		BR_REG      // Target is operand 2
	} branch_op_e;

	// MIPS Cause ExcCode values
	typedef enum logic [4:0] {
		EXC_NONE = 5'd0,
		EXC_SYS  = 5'd8,
		EXC_RI   = 5'd10
	} exc_code_e;

	// Primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// SPECIAL function field
	localparam logic [5:0] FN_SLL     = 6'h00;
	localparam logic [5:0] FN_SRL     = 6'h02;
	localparam logic [5:0] FN_SRA     = 6'h03;
	localparam logic [5:0] FN_JR      = 6'h08;
	localparam logic [5:0] FN_JALR    = 6'h09;
	localparam logic [5:0] FN_SYSCALL = 6'h0c;
	localparam logic [5:0] FN_ADDU    = 6'h21;
	localparam logic [5:0] FN_SUBU    = 6'h23;
	localparam logic [5:0] FN_AND     = 6'h24;
	localparam logic [5:0] FN_OR      = 6'h25;
	localparam logic [5:0] FN_XOR     = 6'h26;
	localparam logic [5:0] FN_NOR     = 6'h27;
	localparam logic [5:0] FN_SLT     = 6'h2a;
	localparam logic [5:0] FN_SLTU    = 6'h2b;

endpackage

`default_nettype wire

/* decode/decode_stage.sv */
// Decode stage: splits the instruction, resolves operands by forwarding and registers the result
`timescale 1ns/10ps
`default_nettype none

module decode_stage import mips_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  instr_valid,
	input  wire logic [31:0]           instr,
	input  wire logic [XLEN-1:0]       instr_pc,
	input  wire logic [XLEN-1:0]       rf_rdata1,
	input  wire logic [XLEN-1:0]       rf_rdata2,
	input  wire logic                  x_fwd_en,
	input  wire logic [REG_ADDR_W-1:0] x_fwd_addr,
	input  wire logic [XLEN-1:0]       x_fwd_data,
	input  wire logic                  rf_we,
	input  wire logic [REG_ADDR_W-1:0] rf_waddr,
	input  wire logic [XLEN-1:0]       rf_wdata,
	output logic [REG_ADDR_W-1:0]      rf_raddr1,
	output logic [REG_ADDR_W-1:0]      rf_raddr2,
	output logic                       d_valid,
	output alu_op_e                    d_alu_op,
	output logic [XLEN-1:0]            d_opr1,
	output logic [XLEN-1:0]            d_opr2,
	output logic [4:0]                 d_shamt,
	output logic                       d_wb_en,
	output logic [REG_ADDR_W-1:0]      d_wb_addr,
	output branch_op_e                 d_branch_op,
	output logic [XLEN-1:0]            d_branch_target,
	output logic [XLEN-1:0]            d_pc,
	output exc_code_e                  d_exc_code
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [REG_ADDR_W-1:0] rs, rt, rd;
	logic [XLEN-1:0] imm_sext, imm_zext;
	logic [XLEN-1:0] pc_plus4, pc_plus8;
	logic [XLEN-1:0] target_rel, target_region;
	logic [XLEN-1:0] rs_val, rt_val;

	alu_op_e         alu_op;
	logic [XLEN-1:0] opr1, opr2;
	logic            wb_en;
	logic [REG_ADDR_W-1:0] wb_addr;
	branch_op_e      branch_op;
	logic [XLEN-1:0] branch_target;
	exc_code_e       exc_code;

	assign opcode   = instr[31:26];
	assign funct    = instr[5:0];
	assign rs       = instr[25:21];
	assign rt       = instr[20:16];
	assign rd       = instr[15:11];
	assign imm_sext = {{16{instr[15]}}, instr[15:0]};
	assign imm_zext = {16'b0, instr[15:0]};

	assign pc_plus4      = instr_pc + 32'd4;
	assign pc_plus8      = instr_pc + 32'd8;
	assign target_rel    = pc_plus4 + {imm_sext[29:0], 2'b00};
	assign target_region = {pc_plus4[31:28], instr[25:0], 2'b00};  // 256 MB region jump

	assign rf_raddr1 = rs;
	assign rf_raddr2 = rt;

	// Execute result is younger, so it wins over the write port
	assign rs_val = (rs == '0) ? '0 :
		(x_fwd_en && x_fwd_addr == rs) ? x_fwd_data :
		(rf_we && rf_waddr == rs) ? rf_wdata : rf_rdata1;
	assign rt_val = (rt == '0) ? '0 :
		(x_fwd_en && x_fwd_addr == rt) ? x_fwd_data :
		(rf_we && rf_waddr == rt) ? rf_wdata : rf_rdata2;

	always_comb begin
		alu_op        = ALU_NONE;
		opr1          = rs_val;
		opr2          = rt_val;
		wb_en         = 1'b0;
		wb_addr       = rt;  // I-type destination unless overridden
		branch_op     = BR_NONE;
		branch_target = target_rel;
		exc_code      = EXC_NONE;
		case (opcode)
			OP_SPECIAL: begin
				wb_en   = 1'b1;
				wb_addr = rd;
				case (funct)
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					FN_SRA:  alu_op = ALU_SRA;
					FN_ADDU: alu_op = ALU_ADDU;
					FN_SUBU: alu_op = ALU_SUBU;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_NOR:  alu_op = ALU_NOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					FN_JR: begin
						wb_en     = 1'b0;
						opr2      = rs_val;
						branch_op = BR_REG;
					end
					FN_JALR: begin
						alu_op    = ALU_PASS1;
						opr1      = pc_plus8;
						opr2      = rs_val;
						branch_op = BR_REG;
					end
					FN_SYSCALL: begin
						wb_en    = 1'b0;
						exc_code = EXC_SYS;
					end
					default: begin
						wb_en    = 1'b0;
						exc_code = EXC_RI;
					end
				endcase
			end
			OP_REGIMM: begin
				if (rt == 5'd1) begin  // BGEZ, taken when rs < 0 is false
					alu_op    = ALU_SLT;
					opr2      = '0;
					branch_op = BR_EQZ;
				end else
					exc_code = EXC_RI;
			end
			OP_BGTZ: begin
				if (rt == '0) begin  // Taken when 0 < rs
					alu_op    = ALU_SLT;
					opr1      = '0;
					opr2      = rs_val;
					branch_op = BR_NEZ;
				end else
					exc_code = EXC_RI;
			end
			OP_BEQ: begin
				alu_op    = ALU_XOR;
				branch_op = BR_EQZ;
			end
			OP_BNE: begin
				alu_op    = ALU_XOR;
				branch_op = BR_NEZ;
			end
			OP_J: begin
				branch_op     = BR_UNCOND;
				branch_target = target_region;
			end
			OP_JAL: begin
				alu_op        = ALU_PASS1;
				opr1          = pc_plus8;
				wb_en         = 1'b1;
				wb_addr       = 5'd31;
				branch_op     = BR_UNCOND;
				branch_target = target_region;
			end
			OP_ADDIU: begin
				alu_op = ALU_ADDU;
				opr2   = imm_sext;
				wb_en  = 1'b1;
			end
			OP_ANDI: begin
				alu_op = ALU_AND;
				opr2   = imm_zext;
				wb_en  = 1'b1;
			end
			OP_ORI: begin
				alu_op = ALU_OR;
				opr2   = imm_zext;
				wb_en  = 1'b1;
			end
			OP_XORI: begin
				alu_op = ALU_XOR;
				opr2   = imm_zext;
				wb_en  = 1'b1;
			end
			OP_LUI: begin
				alu_op = ALU_LUI;  // Shifted up in execute
				opr2   = imm_zext;
				wb_en  = 1'b1;
			end
			default: exc_code = EXC_RI;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			d_valid     <= 1'b0;
			d_wb_en     <= 1'b0;
			d_branch_op <= BR_NONE;
			d_exc_code  <= EXC_NONE;
		end else begin
			d_valid <= instr_valid;
			if (instr_valid) begin
				d_wb_en     <= wb_en;
				d_branch_op <= branch_op;
				d_exc_code  <= exc_code;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			d_alu_op        <= alu_op;
			d_opr1          <= opr1;
			d_opr2          <= opr2;
			d_shamt         <= instr[10:6];
			d_wb_addr       <= wb_addr;
			d_branch_target <= branch_target;
			d_pc            <= instr_pc;
		end
	end

	a_instr_known: assert property (@(posedge clk) disable iff (rst)
		instr_valid |-> !$isunknown(instr));

endmodule

`default_nettype wire

/* decode/register_file.sv */
// Architectural register file, read combinationally by decode and written by the result stage
`timescale 1ns/10ps
`default_nettype none

module register_file import mips_pkg::*; (
	input  wire logic                  clk,
	input  wire logic [REG_ADDR_W-1:0] raddr1,
	input  wire logic [REG_ADDR_W-1:0] raddr2,
	input  wire logic                  we,
	input  wire logic [REG_ADDR_W-1:0] waddr,
	input  wire logic [XLEN-1:0]       wdata,
	output logic [XLEN-1:0]            rdata1,
	output logic [XLEN-1:0]            rdata2
);

	// No storage behind register 0
	logic [XLEN-1:0] regs [1:(1 << REG_ADDR_W) - 1];

	always_ff @(posedge clk) begin
		if (we && waddr != '0)
			regs[waddr] <= wdata;
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	// A write to an unknown address would corrupt the whole file
	a_waddr_known: assert property (@(posedge clk)
		we |-> !$isunknown(waddr));

endmodule

`default_nettype wire

/* design/execute_stage.sv */
// Execute stage: ALU on the decoded operands, result exposed for forwarding and then registered
`timescale 1ns/10ps
`default_nettype none

module execute_stage import mips_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  d_valid,
	input  alu_op_e                    d_alu_op,
	input  wire logic [XLEN-1:0]       d_opr1,
	input  wire logic [XLEN-1:0]       d_opr2,
	input  wire logic [4:0]            d_shamt,
	input  wire logic                  d_wb_en,
	input  wire logic [REG_ADDR_W-1:0] d_wb_addr,
	input  branch_op_e                 d_branch_op,
	input  wire logic [XLEN-1:0]       d_branch_target,
	input  wire logic [XLEN-1:0]       d_pc,
	input  exc_code_e                  d_exc_code,
	output logic                       x_fwd_en,
	output logic [REG_ADDR_W-1:0]      x_fwd_addr,
	output logic [XLEN-1:0]            x_fwd_data,
	output logic                       e_valid,
	output logic [XLEN-1:0]            e_result,
	output logic [XLEN-1:0]            e_opr2,
	output logic                       e_wb_en,
	output logic [REG_ADDR_W-1:0]      e_wb_addr,
	output branch_op_e                 e_branch_op,
	output logic [XLEN-1:0]            e_branch_target,
	output logic [XLEN-1:0]            e_pc,
	output exc_code_e                  e_exc_code
);

	logic [XLEN-1:0] alu_result;

	always_comb begin
		case (d_alu_op)
			ALU_ADDU:  alu_result = d_opr1 + d_opr2;
			ALU_SUBU:  alu_result = d_opr1 - d_opr2;
			ALU_AND:   alu_result = d_opr1 & d_opr2;
			ALU_OR:    alu_result = d_opr1 | d_opr2;
			ALU_XOR:   alu_result = d_opr1 ^ d_opr2;
			ALU_NOR:   alu_result = ~(d_opr1 | d_opr2);
			ALU_SLT:   alu_result = {{(XLEN-1){1'b0}}, $signed(d_opr1) < $signed(d_opr2)};
			ALU_SLTU:  alu_result = {{(XLEN-1){1'b0}}, d_opr1 < d_opr2};
			ALU_SLL:   alu_result = d_opr2 << d_shamt;  // Shifts act on rt
			ALU_SRL:   alu_result = d_opr2 >> d_shamt;
			ALU_SRA:   alu_result = $signed(d_opr2) >>> d_shamt;
			ALU_LUI:   alu_result = {d_opr2[15:0], 16'b0};
			ALU_PASS1: alu_result = d_opr1;
			default:   alu_result = '0;
		endcase
	end

	assign x_fwd_en   = d_valid && d_wb_en;
	assign x_fwd_addr = d_wb_addr;
	assign x_fwd_data = alu_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			e_valid     <= 1'b0;
			e_wb_en     <= 1'b0;
			e_branch_op <= BR_NONE;
			e_exc_code  <= EXC_NONE;
		end else begin
			e_valid     <= d_valid;
			e_wb_en     <= d_wb_en;
			e_branch_op <= d_branch_op;
			e_exc_code  <= d_exc_code;
		end
	end

	// Payload follows the valid slot
	always_ff @(posedge clk) begin
		e_result        <= alu_result;
		e_opr2          <= d_opr2;
		e_wb_addr       <= d_wb_addr;
		e_branch_target <= d_branch_target;
		e_pc            <= d_pc;
	end

endmodule

`default_nettype wire

/* design/mips_core.sv */
// Top level of the three-stage core, fed by an external fetcher with strobed instructions
`timescale 1ns/10ps
`default_nettype none

module mips_core import mips_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  instr_valid,
	input  wire logic [31:0]           instr,
	input  wire logic [XLEN-1:0]       instr_pc,
	output logic                       wb_valid,
	output logic [REG_ADDR_W-1:0]      wb_addr,
	output logic [XLEN-1:0]            wb_data,
	output logic                       br_valid,
	output logic [XLEN-1:0]            br_target,
	output logic                       exc_valid,
	output exc_code_e                  exc_code,
	output logic [XLEN-1:0]            exc_epc
);

	logic [REG_ADDR_W-1:0] rf_raddr1, rf_raddr2;
	logic [XLEN-1:0]       rf_rdata1, rf_rdata2;
	logic                  rf_we;
	logic [REG_ADDR_W-1:0] rf_waddr;
	logic [XLEN-1:0]       rf_wdata;

	logic                  x_fwd_en;
	logic [REG_ADDR_W-1:0] x_fwd_addr;
	logic [XLEN-1:0]       x_fwd_data;

	// Decode to execute
	logic                  d_valid, d_wb_en;
	alu_op_e               d_alu_op;
	logic [XLEN-1:0]       d_opr1, d_opr2, d_branch_target, d_pc;
	logic [4:0]            d_shamt;
	logic [REG_ADDR_W-1:0] d_wb_addr;
	branch_op_e            d_branch_op;
	exc_code_e             d_exc_code;

	// Execute to result
	logic                  e_valid, e_wb_en;
	logic [XLEN-1:0]       e_result, e_opr2, e_branch_target, e_pc;
	logic [REG_ADDR_W-1:0] e_wb_addr;
	branch_op_e            e_branch_op;
	exc_code_e             e_exc_code;

	decode_stage i_decode (.*);

	register_file i_register_file (
		.clk(clk), .raddr1(rf_raddr1), .raddr2(rf_raddr2),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
		.rdata1(rf_rdata1), .rdata2(rf_rdata2)
	);

	execute_stage i_execute (.*);

	result_stage i_result (.*);

endmodule

`default_nettype wire

/* design/result_stage.sv */
// Result stage: register writeback, branch resolution and exception reporting to the fetcher
`timescale 1ns/10ps
`default_nettype none

module result_stage import mips_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  e_valid,
	input  wire logic [XLEN-1:0]       e_result,
	input  wire logic [XLEN-1:0]       e_opr2,
	input  wire logic                  e_wb_en,
	input  wire logic [REG_ADDR_W-1:0] e_wb_addr,
	input  branch_op_e                 e_branch_op,
	input  wire logic [XLEN-1:0]       e_branch_target,
	input  wire logic [XLEN-1:0]       e_pc,
	input  exc_code_e                  e_exc_code,
	output logic                       rf_we,
	output logic [REG_ADDR_W-1:0]      rf_waddr,
	output logic [XLEN-1:0]            rf_wdata,
	output logic                       wb_valid,
	output logic [REG_ADDR_W-1:0]      wb_addr,
	output logic [XLEN-1:0]            wb_data,
	output logic                       br_valid,
	output logic [XLEN-1:0]            br_target,
	output logic                       exc_valid,
	output exc_code_e                  exc_code,
	output logic [XLEN-1:0]            exc_epc
);

	logic taken;
	logic has_exc;

	assign has_exc = e_exc_code != EXC_NONE;

	always_comb begin
		case (e_branch_op)
			BR_EQZ:    taken = e_result == '0;
			BR_NEZ:    taken = e_result != '0;
			BR_UNCOND: taken = 1'b1;
			BR_REG:    taken = 1'b1;
			default:   taken = 1'b0;
		endcase
	end

	// Register 0 writes are dropped here too
	assign rf_we    = e_valid && e_wb_en && !has_exc && e_wb_addr != '0;
	assign rf_waddr = e_wb_addr;
	assign rf_wdata = e_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid  <= 1'b0;
			br_valid  <= 1'b0;
			exc_valid <= 1'b0;
		end else begin
			wb_valid  <= rf_we;
			br_valid  <= e_valid && taken && !has_exc;
			exc_valid <= e_valid && has_exc;
		end
	end

	always_ff @(posedge clk) begin
		wb_addr   <= rf_waddr;
		wb_data   <= rf_wdata;
		br_target <= (e_branch_op == BR_REG) ? e_opr2 : e_branch_target;
		exc_code  <= e_exc_code;
		exc_epc   <= e_pc;  // Faulting instruction itself
	end

	// Decode never hands over a faulting slot that also branches or writes
	a_br_exc_excl: assert property (@(posedge clk) disable iff (rst)
		e_valid && has_exc |-> e_branch_op == BR_NONE);
	a_wb_exc_excl: assert property (@(posedge clk) disable iff (rst)
		e_valid && has_exc |-> !e_wb_en);

endmodule

`default_nettype wire

/* mips_core_lite.f */
+incdir+tb
common/mips_pkg.sv
decode/register_file.sv
decode/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/mips_core.sv
tb/tb_mips_core.sv

/* tb/mips_model.svh */
// Reference model and random instruction generator, included inside the core testbench module
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH
`default_nettype none

// Expected outputs of one issued instruction
typedef struct packed {
	int          due;  // Edge at which the outputs get registered
	bit          wb;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;
	bit          br;
	logic [31:0] br_target;
	bit          exc;
	logic [4:0]  exc_code;
	logic [31:0] exc_epc;
} expect_t;

logic [31:0] model_regs [0:31];

function automatic logic [4:0] pick_reg();
	if ($urandom_range(0, 3) == 0)
		return 5'($urandom_range(0, 31));
	return 5'($urandom_range(0, 7));  // Small pool so hazards are frequent
endfunction

function automatic logic [31:0] gen_instr(input int idx);
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [4:0]  sh;
	logic [15:0] imm;
	int unsigned pick;
	rs   = pick_reg();
	rt   = pick_reg();
	rd   = pick_reg();
	sh   = 5'($urandom_range(0, 31));
	imm  = 16'($urandom());
	pick = $urandom_range(0, 99);
	if (idx < 31)
		return {6'h09, 5'd0, 5'(idx + 1), imm};  // ADDIU rN, r0, imm
	if (pick < 5)
		return {6'h20 + 6'($urandom_range(0, 15)), 26'($urandom())};  // Loads and stores
	if (pick < 40) begin
		case ($urandom_range(0, 10))
			0: return {6'h00, rs, rt, rd, 5'd0, 6'h21};
			1: return {6'h00, rs, rt, rd, 5'd0, 6'h23};
			2: return {6'h00, rs, rt, rd, 5'd0, 6'h24};
			3: return {6'h00, rs, rt, rd, 5'd0, 6'h25};
			4: return {6'h00, rs, rt, rd, 5'd0, 6'h26};
			5: return {6'h00, rs, rt, rd, 5'd0, 6'h27};
			6: return {6'h00, rs, rt, rd, 5'd0, 6'h2a};
			7: return {6'h00, rs, rt, rd, 5'd0, 6'h2b};
			8: return {6'h00, 5'd0, rt, rd, sh, 6'h00};
			9: return {6'h00, 5'd0, rt, rd, sh, 6'h02};
			default: return {6'h00, 5'd0, rt, rd, sh, 6'h03};
		endcase
	end
	if (pick < 65) begin
		case ($urandom_range(0, 4))
			0: return {6'h09, rs, rt, imm};
			1: return {6'h0c, rs, rt, imm};
			2: return {6'h0d, rs, rt, imm};
			3: return {6'h0e, rs, rt, imm};
			default: return {6'h0f, 5'd0, rt, imm};
		endcase
	end
	if (pick < 85) begin
		if ($urandom_range(0, 2) == 0)
			rt = rs;  // Forces some taken BEQ
		case ($urandom_range(0, 3))
			0: return {6'h04, rs, rt, imm};
			1: return {6'h05, rs, rt, imm};
			2: return {6'h01, rs, 5'd1, imm};  // BGEZ
			default: return {6'h07, rs, 5'd0, imm};  // BGTZ
		endcase
	end
	if (pick < 96) begin
		case ($urandom_range(0, 3))
			0: return {6'h02, 26'($urandom())};
			1: return {6'h03, 26'($urandom())};
			2: return {6'h00, rs, 15'd0, 6'h08};
			default: return {6'h00, rs, 5'd0, rd, 5'd0, 6'h09};
		endcase
	end
	return {6'h00, 20'($urandom()), 6'h0c};  // SYSCALL with a random code field
endfunction

// Runs one instruction on the model registers and returns what the core must report
function automatic expect_t model_exec(input logic [31:0] w, input logic [31:0] pc);
	expect_t     e;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  sh;
	logic [4:0]  dst;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] zimm;
	logic [31:0] pc4;
	logic [31:0] rel;
	logic [31:0] val;
	bit          wr;
	rs   = w[25:21];
	rt   = w[20:16];
	sh   = w[10:6];
	a    = (rs == 5'd0) ? 32'd0 : model_regs[rs];
	b    = (rt == 5'd0) ? 32'd0 : model_regs[rt];
	simm = {{16{w[15]}}, w[15:0]};
	zimm = {16'd0, w[15:0]};
	pc4  = pc + 32'd4;
	rel  = pc4 + {simm[29:0], 2'b00};
	e    = '0;
	e.exc_epc = pc;
	wr   = 1'b0;
	dst  = rt;
	val  = 32'd0;
	case (w[31:26])
		6'h00: begin
			wr  = 1'b1;
			dst = w[15:11];
			case (w[5:0])
				6'h21: val = a + b;
				6'h23: val = a - b;
				6'h24: val = a & b;
				6'h25: val = a | b;
				6'h26: val = a ^ b;
				6'h27: val = ~(a | b);
				6'h2a: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				6'h2b: val = (a < b) ? 32'd1 : 32'd0;
				6'h00: val = b << sh;
				6'h02: val = b >> sh;
				6'h03: val = $signed(b) >>> sh;
				6'h08: begin
					wr          = 1'b0;
					e.br        = 1'b1;
					e.br_target = a;
				end
				6'h09: begin
					val         = pc + 32'd8;  // Link
					e.br        = 1'b1;
					e.br_target = a;
				end
				6'h0c: begin
					e.exc      = 1'b1;
					e.exc_code = 5'd8;
				end
				default: begin
					e.exc      = 1'b1;
					e.exc_code = 5'd10;
				end
			endcase
		end
		6'h01: begin
			if (rt == 5'd1) begin
				e.br        = !a[31];
				e.br_target = rel;
			end else begin
				e.exc      = 1'b1;
				e.exc_code = 5'd10;
			end
		end
		6'h07: begin
			if (rt == 5'd0) begin
				e.br        = !a[31] && a != 32'd0;
				e.br_target = rel;
			end else begin
				e.exc      = 1'b1;
				e.exc_code = 5'd10;
			end
		end
		6'h04: begin
			e.br        = a == b;
			e.br_target = rel;
		end
		6'h05: begin
			e.br        = a != b;
			e.br_target = rel;
		end
		6'h02: begin
			e.br        = 1'b1;
			e.br_target = {pc4[31:28], w[25:0], 2'b00};
		end
		6'h03: begin
			e.br        = 1'b1;
			e.br_target = {pc4[31:28], w[25:0], 2'b00};
			wr          = 1'b1;
			dst         = 5'd31;
			val         = pc + 32'd8;
		end
		6'h09: begin
			wr  = 1'b1;
			val = a + simm;
		end
		6'h0c: begin
			wr  = 1'b1;
			val = a & zimm;
		end
		6'h0d: begin
			wr  = 1'b1;
			val = a | zimm;
		end
		6'h0e: begin
			wr  = 1'b1;
			val = a ^ zimm;
		end
		6'h0f: begin
			wr  = 1'b1;
			val = {w[15:0], 16'd0};
		end
		default: begin
			e.exc      = 1'b1;
			e.exc_code = 5'd10;
		end
	endcase
	e.wb = wr && !e.exc && dst != 5'd0;
	if (e.wb) begin
		e.wb_addr       = dst;
		e.wb_data       = val;
		model_regs[dst] = val;
	end
	return e;
endfunction

`default_nettype wire
`endif

/* tb/tb_mips_core.sv */
// Testbench for the MIPS core: random instruction stream checked against a reference model
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;

	localparam int NUM_INSTR  = 2000;
	localparam int MAX_CYCLES = 4 * NUM_INSTR + 20;
	localparam int SEED       = 43832;

	logic        clk;
	logic        rst;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] instr_pc;
	logic        wb_valid;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;
	logic        br_valid;
	logic [31:0] br_target;
	logic        exc_valid;
	logic [4:0]  exc_code;
	logic [31:0] exc_epc;

	`include "mips_model.svh"

	expect_t exp_q [$];  // In issue order, so due edges only grow
	expect_t due_entry;
	int      edge_cnt  = 0;
	int      cycle_cnt = 0;
	int      error_cnt = 0;

	mips_core i_mips_core (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reads at the same edge still see the index of the previous edge
	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the expected results never all arrived",
				cycle_cnt);
			$display("Testbench failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic report_mismatch(input string what);
		error_cnt++;
		$display("FAIL %0t: %s", $time, what);
		$display("Testbench failed");
		$fatal(1, "Stopping at the first mismatch");
	endtask

	task automatic check_outputs(input expect_t e);
		assert (wb_valid === e.wb)
		else report_mismatch($sformatf("wb_valid %b, expected %b", wb_valid, e.wb));
		if (e.wb) begin
			assert (wb_addr === e.wb_addr && wb_data === e.wb_data)
			else report_mismatch($sformatf("write r%0d=%h, expected r%0d=%h",
				wb_addr, wb_data, e.wb_addr, e.wb_data));
		end
		assert (br_valid === e.br)
		else report_mismatch($sformatf("br_valid %b, expected %b", br_valid, e.br));
		if (e.br) begin
			assert (br_target === e.br_target)
			else report_mismatch($sformatf("br_target %h, expected %h",
				br_target, e.br_target));
		end
		assert (exc_valid === e.exc)
		else report_mismatch($sformatf("exc_valid %b, expected %b", exc_valid, e.exc));
		if (e.exc) begin
			assert (exc_code === e.exc_code && exc_epc === e.exc_epc)
			else report_mismatch($sformatf("exception %0d at %h, expected %0d at %h",
				exc_code, exc_epc, e.exc_code, e.exc_epc));
		end
	endtask

	// Outputs are stable mid cycle
	always @(negedge clk) begin
		if (edge_cnt > 0) begin
			if (exp_q.size() > 0 && exp_q[0].due == edge_cnt) begin
				due_entry = exp_q.pop_front();
				check_outputs(due_entry);
			end else begin
				assert (wb_valid === 1'b0 && br_valid === 1'b0 && exc_valid === 1'b0)
				else report_mismatch("strobe high with no instruction due");
			end
		end
	end

	initial begin
		logic [31:0] word;
		logic [31:0] pc;
		expect_t     entry;
		int          issued;
		void'($urandom(SEED));
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = 32'd0;
		instr_pc    = 32'd0;
		pc          = 32'h0040_0000;
		issued      = 0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		while (issued < NUM_INSTR) begin
			@(posedge clk);
			if ($urandom_range(0, 3) != 0) begin
				word      = gen_instr(issued);
				entry     = model_exec(word, pc);
				entry.due = edge_cnt + 4;  // Sampled at the next edge, out two later
				exp_q.push_back(entry);
				instr_valid <= 1'b1;
				instr       <= word;
				instr_pc    <= pc;
				pc          = pc + 32'd4;
				issued++;
			end else begin
				instr_valid <= 1'b0;
			end
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);  // Idle tail with all strobes low
		if (error_cnt == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1, "Errors were reported during the run");
		end
	end

endmodule

`default_nettype wire
